// File: hw/core_ctrl_settings.svh
/*
 * Widths, setting register addresses and readback word indices
 */

`ifndef CORE_CTRL_SETTINGS_SVH
`define CORE_CTRL_SETTINGS_SVH

//////////////////////////////
// Bus and field widths
//////////////////////////////

`define CC_SET_ADDR_W    8
`define CC_SET_DATA_W    32
`define CC_LED_W         8

// Address bits passed through inside one RAM page
`define CC_PAGE_BITS     10
`define CC_RAM_ADR_W     20
`define CC_BRIDGE_ADR_W  16

`define CC_RB_ADR_W      4
`define CC_NUM_BUF       8

//////////////////////////////
// Setting register map
//////////////////////////////

`define CC_SR_CLK        8'd0
`define CC_SR_SER        8'd1
`define CC_SR_ADC        8'd2
`define CC_SR_LED        8'd3
`define CC_SR_PHY        8'd4
`define CC_SR_PAGE       8'd6
`define CC_SR_ICACHE     8'd7
`define CC_SR_LED_SRC    8'd8

// Readback words above the buffer status block
`define CC_RB_POOL       4'd8
`define CC_RB_BUILD      4'd9

`endif

// File: hw/core_ctrl_pkg.sv
/*
 * Vector types and packed structs of the control plane
 */

`include "core_ctrl_settings.svh"

package core_ctrl_pkg;

   //////////////////////////////
   // Plain vectors
   //////////////////////////////

   typedef logic [`CC_SET_ADDR_W-1:0]   set_addr_t;
   typedef logic [`CC_SET_DATA_W-1:0]   set_data_t;
   typedef logic [`CC_SET_DATA_W-1:0]   status_word_t;
   typedef logic [`CC_LED_W-1:0]        led_t;
   typedef logic [`CC_RAM_ADR_W-1:0]    ram_adr_t;
   typedef logic [`CC_BRIDGE_ADR_W-1:0] bridge_adr_t;
   typedef logic [`CC_RB_ADR_W-1:0]     rb_adr_t;

   //////////////////////////////
   // Structs
   //////////////////////////////

   // Settings write port, one strobe for all registers
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   // Register 0, bits 4..0
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   // Register 1, bits 3..0
   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   // Register 2, bits 3..0
   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   // One status word per buffer
   typedef status_word_t [`CC_NUM_BUF-1:0] buf_status_t;

endpackage

// File: hw/setting_reg.sv
/*
 * Single addressed setting register with a one-cycle changed pulse
 */

`timescale 1ns/1ns

module setting_reg #(
   parameter int unsigned ADDR  = 0,
   parameter int unsigned WIDTH = 32
) (
   input  logic                    dsp_clk,
   input  logic                    rst_n_i,
   input  core_ctrl_pkg::set_bus_t set_i,
   output logic [WIDTH-1:0]        out_o,
   output logic                    changed_o
);

   logic hit;

   // Address decode for this register
   assign hit = set_i.stb && (set_i.addr == core_ctrl_pkg::set_addr_t'(ADDR));

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_o     <= '0;
         changed_o <= 1'b0;
      end else begin
         changed_o <= hit;
         if (hit) begin
            // Only the low bits of the data word are kept
            out_o <= set_i.data[WIDTH-1:0];
         end
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Pulse only follows a matching write on the previous edge
   a_changed_after_write : assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i)
      changed_o |-> $past(set_i.stb && (set_i.addr == core_ctrl_pkg::set_addr_t'(ADDR)))
   ) else $error("changed_o without a matching write");

endmodule

// File: hw/board_ctrl.sv
/*
 * Setting register bank, board control lines,
 * LED source select and paged external-RAM address
 */

`timescale 1ns/1ns

`include "core_ctrl_settings.svh"

module board_ctrl (
   input  logic                         dsp_clk,
   input  logic                         rst_n_i,
   input  core_ctrl_pkg::set_bus_t      set_i,
   input  logic                         clk_status_i,
   input  logic                         link_up_i,
   input  core_ctrl_pkg::bridge_adr_t   bridge_adr_i,
   output core_ctrl_pkg::clock_ctrl_t   clock_o,
   output core_ctrl_pkg::serdes_ctrl_t  serdes_o,
   output core_ctrl_pkg::adc_ctrl_t     adc_o,
   output logic                         phy_resetn_o,
   output logic                         flush_icache_o,
   output core_ctrl_pkg::led_t          leds_o,
   output core_ctrl_pkg::ram_adr_t      ram_adr_o
);

   localparam int unsigned CLK_W = $bits(core_ctrl_pkg::clock_ctrl_t);
   localparam int unsigned SER_W = $bits(core_ctrl_pkg::serdes_ctrl_t);
   localparam int unsigned ADC_W = $bits(core_ctrl_pkg::adc_ctrl_t);

   logic [CLK_W-1:0]        clk_q;
   logic [SER_W-1:0]        ser_q;
   logic [ADC_W-1:0]        adc_q;
   logic                    phy_reset;
   core_ctrl_pkg::led_t     led_sw;
   core_ctrl_pkg::led_t     led_src;
   core_ctrl_pkg::led_t     led_hw;
   core_ctrl_pkg::ram_adr_t page;

   //////////////////////////////
   // Register bank
   //////////////////////////////

   setting_reg #(.ADDR(`CC_SR_CLK), .WIDTH(CLK_W)) sr_clk (
      .dsp_clk, .rst_n_i, .set_i,
      .out_o(clk_q), .changed_o()
   );

   setting_reg #(.ADDR(`CC_SR_SER), .WIDTH(SER_W)) sr_ser (
      .dsp_clk, .rst_n_i, .set_i,
      .out_o(ser_q), .changed_o()
   );

   setting_reg #(.ADDR(`CC_SR_ADC), .WIDTH(ADC_W)) sr_adc (
      .dsp_clk, .rst_n_i, .set_i,
      .out_o(adc_q), .changed_o()
   );

   setting_reg #(.ADDR(`CC_SR_LED), .WIDTH(`CC_LED_W)) sr_led (
      .dsp_clk, .rst_n_i, .set_i,
      .out_o(led_sw), .changed_o()
   );

   setting_reg #(.ADDR(`CC_SR_PHY), .WIDTH(1)) sr_phy (
      .dsp_clk, .rst_n_i, .set_i,
      .out_o(phy_reset), .changed_o()
   );

   setting_reg #(.ADDR(`CC_SR_PAGE), .WIDTH(`CC_RAM_ADR_W)) sr_page (
      .dsp_clk, .rst_n_i, .set_i,
      .out_o(page), .changed_o()
   );

   // Value is ignored, the write itself flushes
   setting_reg #(.ADDR(`CC_SR_ICACHE), .WIDTH(1)) sr_icache (
      .dsp_clk, .rst_n_i, .set_i,
      .out_o(), .changed_o(flush_icache_o)
   );

   setting_reg #(.ADDR(`CC_SR_LED_SRC), .WIDTH(`CC_LED_W)) sr_led_src (
      .dsp_clk, .rst_n_i, .set_i,
      .out_o(led_src), .changed_o()
   );

   //////////////////////////////
   // Control lines
   //////////////////////////////

   assign clock_o  = core_ctrl_pkg::clock_ctrl_t'(clk_q);
   assign serdes_o = core_ctrl_pkg::serdes_ctrl_t'(ser_q);
   assign adc_o    = core_ctrl_pkg::adc_ctrl_t'(adc_q);

   // PHY reset pin is active low
   assign phy_resetn_o = ~phy_reset;

   //////////////////////////////
   // LEDs
   //////////////////////////////

   // Hardware status on the two low LEDs
   assign led_hw = {{(`CC_LED_W-2){1'b0}}, clk_status_i, link_up_i};

   // Source bit set means hardware drives that LED
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   //////////////////////////////
   // External RAM address
   //////////////////////////////

   assign ram_adr_o = {page[`CC_RAM_ADR_W-1:`CC_PAGE_BITS],
                       bridge_adr_i[`CC_PAGE_BITS-1:0]};

endmodule

// File: hw/status_readback.sv
/*
 * Registered readback of buffer, pool and build status words
 */

`timescale 1ns/1ns

`include "core_ctrl_settings.svh"

module status_readback (
   input  logic                         dsp_clk,
   input  logic                         rst_n_i,
   input  logic                         rb_stb_i,
   input  core_ctrl_pkg::rb_adr_t       rb_adr_i,
   input  core_ctrl_pkg::buf_status_t   buf_status_i,
   input  core_ctrl_pkg::status_word_t  pool_status_i,
   input  logic                         sim_mode_i,
   input  logic [3:0]                   clock_divider_i,
   output core_ctrl_pkg::status_word_t  rb_data_o,
   output logic                         rb_ack_o
);

   localparam int unsigned BUF_IDX_W = $clog2(`CC_NUM_BUF);

   core_ctrl_pkg::status_word_t build_word;
   core_ctrl_pkg::status_word_t rb_sel;

   // Sim mode on top, clock divider in the low nibble
   assign build_word = {sim_mode_i, {(`CC_SET_DATA_W-5){1'b0}}, clock_divider_i};

   //////////////////////////////
   // Word select
   //////////////////////////////

   always_comb begin
      rb_sel = '0;
      case (rb_adr_i)
         `CC_RB_POOL:  rb_sel = pool_status_i;
         `CC_RB_BUILD: rb_sel = build_word;
         default: begin
            // Buffer words sit at the bottom, the upper indices read zero
            if (rb_adr_i < `CC_NUM_BUF) begin
               rb_sel = buf_status_i[rb_adr_i[BUF_IDX_W-1:0]];
            end
         end
      endcase
   end

   // Data is captured only on a strobe
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= rb_sel;
      end
   end

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_stb_i;
      end
   end

   // Every acknowledge answers the strobe one cycle before
   a_ack_follows_stb : assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i)
      rb_ack_o |-> $past(rb_stb_i)
   ) else $error("rb_ack_o without a strobe");

endmodule

// File: hw/core_ctrl_top.sv
/*
 * Core control plane top, board control and status readback
 */

`timescale 1ns/1ns

module core_ctrl_top (
   input  logic                         dsp_clk,
   input  logic                         rst_n_i,

   // Settings write port
   input  core_ctrl_pkg::set_bus_t      set_i,

   // Board status and bridge address
   input  logic                         clk_status_i,
   input  logic                         link_up_i,
   input  core_ctrl_pkg::bridge_adr_t   bridge_adr_i,

   // Control lines
   output core_ctrl_pkg::clock_ctrl_t   clock_o,
   output core_ctrl_pkg::serdes_ctrl_t  serdes_o,
   output core_ctrl_pkg::adc_ctrl_t     adc_o,
   output logic                         phy_resetn_o,
   output logic                         flush_icache_o,
   output core_ctrl_pkg::led_t          leds_o,
   output core_ctrl_pkg::ram_adr_t      ram_adr_o,

   // Status readback
   input  logic                         rb_stb_i,
   input  core_ctrl_pkg::rb_adr_t       rb_adr_i,
   input  core_ctrl_pkg::buf_status_t   buf_status_i,
   input  core_ctrl_pkg::status_word_t  pool_status_i,
   input  logic                         sim_mode_i,
   input  logic [3:0]                   clock_divider_i,
   output core_ctrl_pkg::status_word_t  rb_data_o,
   output logic                         rb_ack_o
);

   board_ctrl u_board_ctrl (
      .dsp_clk,
      .rst_n_i,
      .set_i,
      .clk_status_i,
      .link_up_i,
      .bridge_adr_i,
      .clock_o,
      .serdes_o,
      .adc_o,
      .phy_resetn_o,
      .flush_icache_o,
      .leds_o,
      .ram_adr_o
   );

   status_readback u_status_readback (
      .dsp_clk,
      .rst_n_i,
      .rb_stb_i,
      .rb_adr_i,
      .buf_status_i,
      .pool_status_i,
      .sim_mode_i,
      .clock_divider_i,
      .rb_data_o,
      .rb_ack_o
   );

endmodule

// File: verification/core_ctrl_tb.sv
/*
 * Testbench for the core control plane, LFSR stimulus and reference model
 */

`timescale 1ns/1ns

`include "core_ctrl_settings.svh"

module core_ctrl_tb;

   localparam int N_WRITES       = 1500;
   localparam int N_READS        = 800;
   localparam int TIMEOUT_CYCLES = (N_WRITES + N_READS) * 4 + 200;

   logic                         dsp_clk;
   logic                         rst_n_i;
   core_ctrl_pkg::set_bus_t      set_bus;
   logic                         clk_status;
   logic                         link_up;
   core_ctrl_pkg::bridge_adr_t   bridge_adr;
   core_ctrl_pkg::clock_ctrl_t   clock_out;
   core_ctrl_pkg::serdes_ctrl_t  serdes_out;
   core_ctrl_pkg::adc_ctrl_t     adc_out;
   logic                         phy_resetn;
   logic                         flush_icache;
   core_ctrl_pkg::led_t          leds;
   core_ctrl_pkg::ram_adr_t      ram_adr;
   logic                         rb_stb;
   core_ctrl_pkg::rb_adr_t       rb_adr;
   core_ctrl_pkg::buf_status_t   buf_status;
   core_ctrl_pkg::status_word_t  pool_status;
   logic                         sim_mode;
   logic [3:0]                   clock_divider;
   core_ctrl_pkg::status_word_t  rb_data;
   logic                         rb_ack;

   // Reference model state
   logic [4:0]  clk_m;
   logic [3:0]  ser_m;
   logic [3:0]  adc_m;
   logic [7:0]  led_sw_m;
   logic [7:0]  led_src_m;
   logic        phy_m;
   logic [19:0] page_m;
   logic [31:0] lfsr_state;
   int          cycle_count;

   core_ctrl_top DUT (
      .dsp_clk, .rst_n_i, .set_i(set_bus),
      .clk_status_i(clk_status), .link_up_i(link_up), .bridge_adr_i(bridge_adr),
      .clock_o(clock_out), .serdes_o(serdes_out), .adc_o(adc_out),
      .phy_resetn_o(phy_resetn), .flush_icache_o(flush_icache),
      .leds_o(leds), .ram_adr_o(ram_adr),
      .rb_stb_i(rb_stb), .rb_adr_i(rb_adr), .buf_status_i(buf_status),
      .pool_status_i(pool_status), .sim_mode_i(sim_mode),
      .clock_divider_i(clock_divider), .rb_data_o(rb_data), .rb_ack_o(rb_ack)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   //////////////////////////////
   // Random numbers
   //////////////////////////////

   // Fibonacci taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic core_ctrl_pkg::set_addr_t mapped_addr(input logic [2:0] idx);
      case (idx)
         3'd0:    return `CC_SR_CLK;
         3'd1:    return `CC_SR_SER;
         3'd2:    return `CC_SR_ADC;
         3'd3:    return `CC_SR_LED;
         3'd4:    return `CC_SR_PHY;
         3'd5:    return `CC_SR_PAGE;
         3'd6:    return `CC_SR_ICACHE;
         default: return `CC_SR_LED_SRC;
      endcase
   endfunction

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_clock(input string name, input core_ctrl_pkg::clock_ctrl_t exp,
                              input core_ctrl_pkg::clock_ctrl_t act);
      if (act !== exp) report_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_serdes(input string name, input core_ctrl_pkg::serdes_ctrl_t exp,
                               input core_ctrl_pkg::serdes_ctrl_t act);
      if (act !== exp) report_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_adc(input string name, input core_ctrl_pkg::adc_ctrl_t exp,
                            input core_ctrl_pkg::adc_ctrl_t act);
      if (act !== exp) report_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_led(input string name, input core_ctrl_pkg::led_t exp,
                            input core_ctrl_pkg::led_t act);
      if (act !== exp) report_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_ram_adr(input string name, input core_ctrl_pkg::ram_adr_t exp,
                                input core_ctrl_pkg::ram_adr_t act);
      if (act !== exp) report_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_word(input string name, input core_ctrl_pkg::status_word_t exp,
                             input core_ctrl_pkg::status_word_t act);
      if (act !== exp) report_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) report_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic void apply_write(input core_ctrl_pkg::set_bus_t wr);
      if (wr.stb) begin
         case (wr.addr)
            `CC_SR_CLK:     clk_m = wr.data[4:0];
            `CC_SR_SER:     ser_m = wr.data[3:0];
            `CC_SR_ADC:     adc_m = wr.data[3:0];
            `CC_SR_LED:     led_sw_m = wr.data[7:0];
            `CC_SR_PHY:     phy_m = wr.data[0];
            `CC_SR_PAGE:    page_m = wr.data[19:0];
            `CC_SR_LED_SRC: led_src_m = wr.data[7:0];
            default: ;
         endcase
      end
   endfunction

   function automatic core_ctrl_pkg::status_word_t readback_word(input logic [3:0] idx);
      if (idx < `CC_NUM_BUF) return buf_status[idx[2:0]];
      if (idx == 4'd8) return pool_status;
      if (idx == 4'd9) return {sim_mode, 27'd0, clock_divider};
      return '0;
   endfunction

   // Compares every board control output against the model
   task automatic check_board(input logic exp_flush);
      core_ctrl_pkg::clock_ctrl_t  exp_clk;
      core_ctrl_pkg::serdes_ctrl_t exp_ser;
      core_ctrl_pkg::adc_ctrl_t    exp_adc;
      core_ctrl_pkg::led_t         exp_led;
      logic                        hw_bit;
      exp_clk.clock_ready = clk_m[4];
      exp_clk.clk_en      = clk_m[3:2];
      exp_clk.clk_sel     = clk_m[1:0];
      exp_ser = {ser_m[3], ser_m[2], ser_m[1], ser_m[0]};
      exp_adc = {adc_m[3], adc_m[2], adc_m[1], adc_m[0]};
      for (int b = 0; b < `CC_LED_W; b++) begin
         hw_bit = (b == 1) ? clk_status : ((b == 0) ? link_up : 1'b0);
         exp_led[b] = led_src_m[b] ? hw_bit : led_sw_m[b];
      end
      check_clock("clock_o", exp_clk, clock_out);
      check_serdes("serdes_o", exp_ser, serdes_out);
      check_adc("adc_o", exp_adc, adc_out);
      check_bit("phy_resetn_o", ~phy_m, phy_resetn);
      check_bit("flush_icache_o", exp_flush, flush_icache);
      check_led("leds_o", exp_led, leds);
      check_ram_adr("ram_adr_o", {page_m[19:10], bridge_adr[9:0]}, ram_adr);
   endtask

   // Inputs change and checks run 2 ns after the edge
   task automatic next_cycle();
      @(posedge dsp_clk);
      #2;
   endtask

   always @(posedge dsp_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         report_failure($sformatf("Simulation timed out after %0d cycles", cycle_count));
      end
   end

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      logic       exp_ack;
      logic [31:0] exp_data;
      int         reads_done;
      lfsr_state = 32'h72b3;
      cycle_count = 0;
      {clk_m, ser_m, adc_m, led_sw_m, led_src_m, phy_m, page_m} = '0;
      rst_n_i = 1'b0;
      set_bus = '0;
      {clk_status, link_up, bridge_adr} = '0;
      {rb_stb, rb_adr, buf_status, pool_status, sim_mode, clock_divider} = '0;
      repeat (16) @(posedge dsp_clk);
      #2 rst_n_i = 1'b1;
      next_cycle();

      // Reset values
      check_board(1'b0);
      check_bit("rb_ack_o", 1'b0, rb_ack);

      // Random writes mostly to mapped registers
      for (int i = 0; i < N_WRITES; i++) begin
         set_bus.stb = 1'b1;
         if (rand_bits(3) != 32'd7) begin
            set_bus.addr = mapped_addr(3'(rand_bits(3)));
         end else begin
            set_bus.addr = core_ctrl_pkg::set_addr_t'(rand_bits(8));
         end
         set_bus.data = rand_bits(32);
         clk_status = 1'(rand_bits(1));
         link_up = 1'(rand_bits(1));
         bridge_adr = core_ctrl_pkg::bridge_adr_t'(rand_bits(16));
         next_cycle();
         apply_write(set_bus);
         check_board(set_bus.addr == `CC_SR_ICACHE);
      end
      set_bus = '0;

      // Random reads with random status inputs
      reads_done = 0;
      while (reads_done < N_READS) begin
         for (int b = 0; b < `CC_NUM_BUF; b++) buf_status[b] = rand_bits(32);
         pool_status = rand_bits(32);
         sim_mode = 1'(rand_bits(1));
         clock_divider = 4'(rand_bits(4));
         rb_stb = (rand_bits(2) != 32'd0);
         rb_adr = core_ctrl_pkg::rb_adr_t'(rand_bits(4));
         exp_ack = rb_stb;
         exp_data = readback_word(rb_adr);
         if (rb_stb) reads_done++;
         next_cycle();
         check_bit("rb_ack_o", exp_ack, rb_ack);
         if (exp_ack) check_word("rb_data_o", exp_data, rb_data);
         check_bit("flush_icache_o", 1'b0, flush_icache);
      end
      rb_stb = 1'b0;
      next_cycle();
      check_bit("rb_ack_o", 1'b0, rb_ack);

      $display("Test OK");
      $finish;
   end

endmodule

// File: all.f
+incdir+hw
hw/core_ctrl_pkg.sv
hw/setting_reg.sv
hw/board_ctrl.sv
hw/status_readback.sv
hw/core_ctrl_top.sv
verification/core_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the core control plane

VERILATOR ?= verilator
TOP       ?= core_ctrl_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without passing"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
